//--- anti_jitter.sv
`timescale 1ns/1ns
`default_nettype none

module anti_jitter #(
	parameter int WIDTH = 1,
	parameter int DEBOUNCE_MAX = 10000,
	parameter logic [WIDTH-1:0] INIT_VALUE = '0
) (
	input  logic             clk_cpu,
	input  logic             rst_n_i,
	input  logic [WIDTH-1:0] sig_i,
	output logic [WIDTH-1:0] sig_o
);

	localparam int CNT_W = $clog2(DEBOUNCE_MAX + 1);

	logic [WIDTH-1:0] sig_last;
	logic [CNT_W-1:0] stable_cnt [WIDTH];

	always_ff @(posedge clk_cpu or negedge rst_n_i) begin
		if (!rst_n_i) begin
			sig_last <= INIT_VALUE;
			sig_o <= INIT_VALUE;
			for (int i = 0; i < WIDTH; i++) begin
				stable_cnt[i] <= '0;
			end
		end else begin
			sig_last <= sig_i;
			for (int i = 0; i < WIDTH; i++) begin
				// any edge on the raw input restarts this bit's count
				if (sig_i[i] != sig_last[i]) begin
					stable_cnt[i] <= '0;
				end else if (stable_cnt[i] == CNT_W'(DEBOUNCE_MAX)) begin
					sig_o[i] <= sig_i[i];
				end else begin
					stable_cnt[i] <= stable_cnt[i] + 1'b1;
				end
			end
		end
	end

endmodule

`default_nettype wire

//--- ir_conv.sv
`timescale 1ns/1ns
`default_nettype none

module ir_conv #(
	parameter int IR_HOLD = 5
) (
	input  logic                      clk_cpu,
	input  logic                      sys_rst_i,
	input  logic [soc_pkg::IRQ_W-1:0] ir_i,
	output logic [soc_pkg::IRQ_W-1:0] ir_o
);
	import soc_pkg::*;

	localparam int CNT_W = $clog2(IR_HOLD + 1);

	logic [CNT_W-1:0] hold_cnt [IRQ_W];

	always_ff @(posedge clk_cpu or posedge sys_rst_i) begin
		if (sys_rst_i) begin
			ir_o <= '0;
			for (int i = 0; i < IRQ_W; i++) begin
				hold_cnt[i] <= '0;
			end
		end else begin
			for (int i = 0; i < IRQ_W; i++) begin
				// reload while the source is active, drain after it falls
				if (ir_i[i]) begin
					hold_cnt[i] <= CNT_W'(IR_HOLD);
				end else if (hold_cnt[i] != '0) begin
					hold_cnt[i] <= hold_cnt[i] - 1'b1;
				end
				ir_o[i] <= ir_i[i] || (hold_cnt[i] != '0);
			end
		end
	end

endmodule

`default_nettype wire

//--- reset_gen.sv
`timescale 1ns/1ns
`default_nettype none

module reset_gen #(
	parameter int RST_HOLD = 16
) (
	input  logic clk_cpu,
	input  logic rst_n_i,
	output logic sys_rst_o
);

	logic [RST_HOLD-1:0] rst_shift;

	// ones loaded while the pin is low, zeros shifted in after release
	always_ff @(posedge clk_cpu or negedge rst_n_i) begin
		if (!rst_n_i) begin
			rst_shift <= '1;
		end else begin
			rst_shift <= {rst_shift[RST_HOLD-2:0], 1'b0};
		end
	end

	// high until the last one has left the shifter
	assign sys_rst_o = rst_shift[RST_HOLD-1];

endmodule

`default_nettype wire

//--- run_sim.sh
#!/bin/bash
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_soc -f vlog.f -o Vtb_soc

./obj_dir/Vtb_soc 2>&1 | tee sim.log

if grep -q "ALL TESTS PASSED" sim.log; then
	exit 0
else
	echo "simulation did not pass, see sim.log"
	exit 1
fi

//--- soc_pkg.sv
`default_nettype none

package soc_pkg;

	// bus geometry
	localparam int DATA_W = 32;
	localparam int SEL_W = DATA_W / 8;
	localparam int WADDR_W = 30;

	// address map, compared against the high byte-address bits
	localparam logic [7:0] RAM_PAGE = 8'h00;
	localparam logic [15:0] DEV_PAGE = 16'hFFFF;

	// board register word offsets
	localparam logic [5:0] BOARD_REG_SWITCH = 6'd0;
	localparam logic [5:0] BOARD_REG_LED = 6'd1;
	localparam logic [5:0] BOARD_REG_IRQ = 6'd2;

	localparam int SWITCH_W = 8;
	localparam int BUTTON_W = 4;
	localparam int IRQ_W = 2;

	typedef enum logic [1:0] {
		ARB_IDLE,
		ARB_IBUS,
		ARB_DBUS
	} arb_state_e;

	typedef enum logic [1:0] {
		SLV_RAM,
		SLV_BOARD,
		SLV_NONE
	} slave_e;

endpackage

`default_nettype wire

//--- soc_sva.sv
`timescale 1ns/1ns
`default_nettype none

module soc_sva (
	input logic                        clk_cpu,
	input logic                        sys_rst,
	input logic                        ibus_cyc_i,
	input logic                        ibus_stb_i,
	input logic                        ibus_ack_o,
	input logic                        ibus_err_o,
	input logic                        dbus_cyc_i,
	input logic                        dbus_stb_i,
	input logic                        dbus_ack_o,
	input logic                        dbus_err_o,
	input logic [soc_pkg::SWITCH_W-1:0] led_o,
	input logic [soc_pkg::IRQ_W-1:0]    irq_o,
	input soc_pkg::arb_state_e          arb_state
);
	import soc_pkg::*;

	ack_err_excl: assert property (@(posedge clk_cpu)
		!(ibus_ack_o && ibus_err_o) && !(dbus_ack_o && dbus_err_o))
		else $error("ack and err high together on a master port");

	// one ack per strobe
	ibus_single_ack: assert property (@(posedge clk_cpu) disable iff (sys_rst)
		(ibus_ack_o && ibus_stb_i) |=> !(ibus_ack_o && ibus_stb_i))
		else $error("ibus ack held for two cycles");
	dbus_single_ack: assert property (@(posedge clk_cpu) disable iff (sys_rst)
		(dbus_ack_o && dbus_stb_i) |=> !(dbus_ack_o && dbus_stb_i))
		else $error("dbus ack held for two cycles");

	outputs_in_reset: assert property (@(posedge clk_cpu)
		sys_rst |-> (led_o == '0 && irq_o == '0))
		else $error("led_o or irq_o active during reset");

	// no grant from idle without cyc
	ibus_grant_cyc: assert property (@(posedge clk_cpu) disable iff (sys_rst)
		(arb_state == ARB_IDLE && !ibus_cyc_i) |=> arb_state != ARB_IBUS)
		else $error("ibus granted while its cyc was low");
	dbus_grant_cyc: assert property (@(posedge clk_cpu) disable iff (sys_rst)
		(arb_state == ARB_IDLE && !dbus_cyc_i) |=> arb_state != ARB_DBUS)
		else $error("dbus granted while its cyc was low");

endmodule

bind soc_top soc_sva u_sva (
	.clk_cpu   (clk_cpu),
	.sys_rst   (sys_rst),
	.ibus_cyc_i(ibus_cyc_i),
	.ibus_stb_i(ibus_stb_i),
	.ibus_ack_o(ibus_ack_o),
	.ibus_err_o(ibus_err_o),
	.dbus_cyc_i(dbus_cyc_i),
	.dbus_stb_i(dbus_stb_i),
	.dbus_ack_o(dbus_ack_o),
	.dbus_err_o(dbus_err_o),
	.led_o     (led_o),
	.irq_o     (irq_o),
	.arb_state (u_arb.arb_state)
);

`default_nettype wire

//--- soc_top.sv
`timescale 1ns/1ns
`default_nettype none

module soc_top #(
	parameter int RST_HOLD = 16,
	parameter int DEBOUNCE_MAX = 10000,
	parameter int RAM_ADDR_W = 8,
	parameter int IR_HOLD = 5
) (
	input  logic                         clk_cpu,
	input  logic                         rst_n_i,
	input  logic                         ibus_cyc_i,
	input  logic                         ibus_stb_i,
	input  logic                         ibus_we_i,
	input  logic [soc_pkg::WADDR_W-1:0]  ibus_addr_i,
	input  logic [soc_pkg::SEL_W-1:0]    ibus_sel_i,
	input  logic [soc_pkg::DATA_W-1:0]   ibus_wdata_i,
	output logic [soc_pkg::DATA_W-1:0]   ibus_rdata_o,
	output logic                         ibus_ack_o,
	output logic                         ibus_err_o,
	input  logic                         dbus_cyc_i,
	input  logic                         dbus_stb_i,
	input  logic                         dbus_we_i,
	input  logic [soc_pkg::WADDR_W-1:0]  dbus_addr_i,
	input  logic [soc_pkg::SEL_W-1:0]    dbus_sel_i,
	input  logic [soc_pkg::DATA_W-1:0]   dbus_wdata_i,
	output logic [soc_pkg::DATA_W-1:0]   dbus_rdata_o,
	output logic                         dbus_ack_o,
	output logic                         dbus_err_o,
	input  logic [soc_pkg::SWITCH_W-1:0] switch_i,
	input  logic [soc_pkg::BUTTON_W-1:0] button_i,
	output logic [soc_pkg::SWITCH_W-1:0] led_o,
	output logic [soc_pkg::IRQ_W-1:0]    irq_o
);
	import soc_pkg::*;

	logic                sys_rst;
	logic [SWITCH_W-1:0] switch_db;
	logic [BUTTON_W-1:0] button_db;
	logic                s_we;
	logic [WADDR_W-1:0]  s_addr;
	logic [SEL_W-1:0]    s_sel;
	logic [DATA_W-1:0]   s_wdata;
	logic                ram_stb;
	logic [DATA_W-1:0]   ram_rdata;
	logic                ram_ack;
	logic                brd_stb;
	logic [DATA_W-1:0]   brd_rdata;
	logic                brd_ack;
	logic [IRQ_W-1:0]    brd_irq;

	reset_gen #(.RST_HOLD(RST_HOLD)) u_reset_gen (
		.clk_cpu  (clk_cpu),
		.rst_n_i  (rst_n_i),
		.sys_rst_o(sys_rst)
	);

	anti_jitter #(
		.WIDTH       (SWITCH_W),
		.DEBOUNCE_MAX(DEBOUNCE_MAX),
		.INIT_VALUE  ({SWITCH_W{1'b0}})
	) u_aj_switch (
		.clk_cpu(clk_cpu),
		.rst_n_i(rst_n_i),
		.sig_i  (switch_i),
		.sig_o  (switch_db)
	);

	anti_jitter #(
		.WIDTH       (BUTTON_W),
		.DEBOUNCE_MAX(DEBOUNCE_MAX),
		.INIT_VALUE  ({BUTTON_W{1'b0}})
	) u_aj_button (
		.clk_cpu(clk_cpu),
		.rst_n_i(rst_n_i),
		.sig_i  (button_i),
		.sig_o  (button_db)
	);

	wb_arb u_arb (
		.clk_cpu     (clk_cpu),
		.sys_rst_i   (sys_rst),
		.ibus_cyc_i  (ibus_cyc_i),
		.ibus_stb_i  (ibus_stb_i),
		.ibus_we_i   (ibus_we_i),
		.ibus_addr_i (ibus_addr_i),
		.ibus_sel_i  (ibus_sel_i),
		.ibus_wdata_i(ibus_wdata_i),
		.ibus_rdata_o(ibus_rdata_o),
		.ibus_ack_o  (ibus_ack_o),
		.ibus_err_o  (ibus_err_o),
		.dbus_cyc_i  (dbus_cyc_i),
		.dbus_stb_i  (dbus_stb_i),
		.dbus_we_i   (dbus_we_i),
		.dbus_addr_i (dbus_addr_i),
		.dbus_sel_i  (dbus_sel_i),
		.dbus_wdata_i(dbus_wdata_i),
		.dbus_rdata_o(dbus_rdata_o),
		.dbus_ack_o  (dbus_ack_o),
		.dbus_err_o  (dbus_err_o),
		.s_we_o      (s_we),
		.s_addr_o    (s_addr),
		.s_sel_o     (s_sel),
		.s_wdata_o   (s_wdata),
		.ram_stb_o   (ram_stb),
		.ram_rdata_i (ram_rdata),
		.ram_ack_i   (ram_ack),
		.brd_stb_o   (brd_stb),
		.brd_rdata_i (brd_rdata),
		.brd_ack_i   (brd_ack)
	);

	// upper word-address bits alias inside the RAM page
	wb_ram #(.RAM_ADDR_W(RAM_ADDR_W)) u_ram (
		.clk_cpu  (clk_cpu),
		.sys_rst_i(sys_rst),
		.stb_i    (ram_stb),
		.we_i     (s_we),
		.addr_i   (s_addr[RAM_ADDR_W-1:0]),
		.sel_i    (s_sel),
		.wdata_i  (s_wdata),
		.rdata_o  (ram_rdata),
		.ack_o    (ram_ack)
	);

	wb_board u_board (
		.clk_cpu  (clk_cpu),
		.sys_rst_i(sys_rst),
		.stb_i    (brd_stb),
		.we_i     (s_we),
		.addr_i   (s_addr[5:0]),
		.sel_i    (s_sel),
		.wdata_i  (s_wdata),
		.rdata_o  (brd_rdata),
		.ack_o    (brd_ack),
		.switch_i (switch_db),
		.button_i (button_db),
		.led_o    (led_o),
		.irq_o    (brd_irq)
	);

	ir_conv #(.IR_HOLD(IR_HOLD)) u_ir_conv (
		.clk_cpu  (clk_cpu),
		.sys_rst_i(sys_rst),
		.ir_i     (brd_irq),
		.ir_o     (irq_o)
	);

endmodule

`default_nettype wire

//--- tb_soc.sv
`timescale 1ns/1ns
`default_nettype none

module tb_soc;
	import soc_pkg::*;

	localparam int RST_HOLD = 16;
	localparam int DEBOUNCE_MAX = 4;
	localparam int RAM_ADDR_W = 8;
	localparam int IR_HOLD = 5;
	localparam int BUS_TIMEOUT = 40;
	localparam logic [WADDR_W-1:0] BRD_BASE = {DEV_PAGE, 14'h0000};
	// byte address 0x1000_0000
	localparam logic [WADDR_W-1:0] UNMAPPED_ADDR = 30'h0400_0000;

	logic                clk_cpu;
	logic                rst_n_i;
	logic                ibus_cyc;
	logic                ibus_stb;
	logic                ibus_we;
	logic [WADDR_W-1:0]  ibus_addr;
	logic [SEL_W-1:0]    ibus_sel;
	logic [DATA_W-1:0]   ibus_wdata;
	logic [DATA_W-1:0]   ibus_rdata;
	logic                ibus_ack;
	logic                ibus_err;
	logic                dbus_cyc;
	logic                dbus_stb;
	logic                dbus_we;
	logic [WADDR_W-1:0]  dbus_addr;
	logic [SEL_W-1:0]    dbus_sel;
	logic [DATA_W-1:0]   dbus_wdata;
	logic [DATA_W-1:0]   dbus_rdata;
	logic                dbus_ack;
	logic                dbus_err;
	logic [SWITCH_W-1:0] switch_i;
	logic [BUTTON_W-1:0] button_i;
	logic [SWITCH_W-1:0] led_o;
	logic [IRQ_W-1:0]    irq_o;

	logic [DATA_W-1:0] ram_model [2**RAM_ADDR_W];
	int                errors = 0;

	soc_top #(
		.RST_HOLD    (RST_HOLD),
		.DEBOUNCE_MAX(DEBOUNCE_MAX),
		.RAM_ADDR_W  (RAM_ADDR_W),
		.IR_HOLD     (IR_HOLD)
	) u_dut (
		.clk_cpu     (clk_cpu),
		.rst_n_i     (rst_n_i),
		.ibus_cyc_i  (ibus_cyc),
		.ibus_stb_i  (ibus_stb),
		.ibus_we_i   (ibus_we),
		.ibus_addr_i (ibus_addr),
		.ibus_sel_i  (ibus_sel),
		.ibus_wdata_i(ibus_wdata),
		.ibus_rdata_o(ibus_rdata),
		.ibus_ack_o  (ibus_ack),
		.ibus_err_o  (ibus_err),
		.dbus_cyc_i  (dbus_cyc),
		.dbus_stb_i  (dbus_stb),
		.dbus_we_i   (dbus_we),
		.dbus_addr_i (dbus_addr),
		.dbus_sel_i  (dbus_sel),
		.dbus_wdata_i(dbus_wdata),
		.dbus_rdata_o(dbus_rdata),
		.dbus_ack_o  (dbus_ack),
		.dbus_err_o  (dbus_err),
		.switch_i    (switch_i),
		.button_i    (button_i),
		.led_o       (led_o),
		.irq_o       (irq_o)
	);

	initial begin
		clk_cpu = 1'b0;
		forever #4 clk_cpu = ~clk_cpu;
	end

	task automatic compare_word(input string name, input logic [DATA_W-1:0] expected,
			input logic [DATA_W-1:0] actual);
		assert (actual === expected) else begin
			$display("Mismatch at %0t ns: %s expected %h, got %h", $time, name, expected,
				actual);
			errors++;
		end
	endtask

	task automatic expect_true(input bit cond, input string what);
		assert (cond) else begin
			$display("Error at %0t ns: %s", $time, what);
			errors++;
		end
	endtask

	task automatic drive_req(input bit use_dbus, input bit active, input bit we,
			input logic [WADDR_W-1:0] addr, input logic [SEL_W-1:0] sel,
			input logic [DATA_W-1:0] wdata);
		if (use_dbus) begin
			dbus_cyc = active;
			dbus_stb = active;
			dbus_we = we;
			dbus_addr = addr;
			dbus_sel = sel;
			dbus_wdata = wdata;
		end else begin
			ibus_cyc = active;
			ibus_stb = active;
			ibus_we = we;
			ibus_addr = addr;
			ibus_sel = sel;
			ibus_wdata = wdata;
		end
	endtask

	// one classic cycle; returns at the falling edge that releases the bus
	task automatic bus_xfer(input bit use_dbus, input bit we, input logic [WADDR_W-1:0] addr,
			input logic [SEL_W-1:0] sel, input logic [DATA_W-1:0] wdata,
			output logic [DATA_W-1:0] rdata, output bit acked, output bit erred,
			output time t_done);
		int cycles;
		bit seen;
		cycles = 0;
		seen = 1'b0;
		acked = 1'b0;
		erred = 1'b0;
		rdata = '0;
		t_done = 0;
		@(negedge clk_cpu);
		drive_req(use_dbus, 1'b1, we, addr, sel, wdata);
		while (!seen && cycles < BUS_TIMEOUT) begin
			@(negedge clk_cpu);
			cycles++;
			acked = use_dbus ? dbus_ack : ibus_ack;
			erred = use_dbus ? dbus_err : ibus_err;
			rdata = use_dbus ? dbus_rdata : ibus_rdata;
			if (acked || erred) begin
				seen = 1'b1;
				t_done = $time;
			end
		end
		expect_true(seen, $sformatf("no ack or err on %s for address %h",
			use_dbus ? "dbus" : "ibus", addr));
		// master takes the response at the next rising edge
		@(negedge clk_cpu);
		drive_req(use_dbus, 1'b0, 1'b0, '0, '0, '0);
	endtask

	task automatic bus_write(input bit use_dbus, input logic [WADDR_W-1:0] addr,
			input logic [SEL_W-1:0] sel, input logic [DATA_W-1:0] data);
		logic [DATA_W-1:0] unused_rdata;
		bit acked;
		bit erred;
		time t_done;
		bus_xfer(use_dbus, 1'b1, addr, sel, data, unused_rdata, acked, erred, t_done);
		expect_true(acked && !erred, $sformatf("write to %h was not acked", addr));
	endtask

	task automatic bus_read(input bit use_dbus, input logic [WADDR_W-1:0] addr,
			output logic [DATA_W-1:0] data);
		bit acked;
		bit erred;
		time t_done;
		bus_xfer(use_dbus, 1'b0, addr, '1, '0, data, acked, erred, t_done);
		expect_true(acked && !erred, $sformatf("read from %h was not acked", addr));
	endtask

	task automatic wait_cycles(input int n);
		repeat (n) @(negedge clk_cpu);
	endtask

	function automatic logic [DATA_W-1:0] merge_bytes(input logic [DATA_W-1:0] old_word,
			input logic [DATA_W-1:0] new_word, input logic [SEL_W-1:0] sel);
		logic [DATA_W-1:0] result;
		result = old_word;
		for (int b = 0; b < SEL_W; b++) begin
			if (sel[b]) begin
				result[8*b +: 8] = new_word[8*b +: 8];
			end
		end
		return result;
	endfunction

	function automatic logic [DATA_W-1:0] fill_pattern(input logic [RAM_ADDR_W-1:0] idx);
		return {idx, ~idx, idx ^ 8'h5A, {idx[3:0], idx[7:4]} ^ 8'hC3};
	endfunction

	// random upper bits alias onto the same RAM word
	function automatic logic [WADDR_W-1:0] ram_word(input logic [RAM_ADDR_W-1:0] idx);
		return {RAM_PAGE, 14'($urandom), idx};
	endfunction

	function automatic logic [WADDR_W-1:0] brd_word(input logic [5:0] offset);
		return BRD_BASE | WADDR_W'(offset);
	endfunction

	initial begin
		logic [DATA_W-1:0] rdata;
		logic [DATA_W-1:0] wdata;
		logic [DATA_W-1:0] rd_d;
		logic [DATA_W-1:0] rd_i;
		logic [SEL_W-1:0] sel;
		logic [RAM_ADDR_W-1:0] idx;
		logic [RAM_ADDR_W-1:0] idx_b;
		bit ack_d;
		bit err_d;
		bit ack_i;
		bit err_i;
		time t_d;
		time t_i;
		int tries;

		void'($urandom(88));
		rst_n_i = 1'b0;
		switch_i = '0;
		button_i = '0;
		drive_req(1'b0, 1'b0, 1'b0, '0, '0, '0);
		drive_req(1'b1, 1'b0, 1'b0, '0, '0, '0);
		wait_cycles(10);
		rst_n_i = 1'b1;
		tries = 0;
		while (u_dut.sys_rst && tries < RST_HOLD + 8) begin
			@(negedge clk_cpu);
			tries++;
		end
		expect_true(!u_dut.sys_rst, "system reset was not released");
		compare_word("led_o", '0, DATA_W'(led_o));
		compare_word("irq_o", '0, DATA_W'(irq_o));

		// RAM fill followed by random byte-lane writes read back by the other master
		for (int i = 0; i < 2**RAM_ADDR_W; i++) begin
			idx = RAM_ADDR_W'(i);
			ram_model[idx] = fill_pattern(idx);
			bus_write(idx[0], ram_word(idx), '1, ram_model[idx]);
		end
		for (int n = 0; n < 48; n++) begin
			idx = RAM_ADDR_W'($urandom);
			sel = SEL_W'($urandom);
			wdata = $urandom;
			bus_write(n[0], ram_word(idx), sel, wdata);
			ram_model[idx] = merge_bytes(ram_model[idx], wdata, sel);
			bus_read(!n[0], ram_word(idx), rdata);
			compare_word(n[0] ? "ibus_rdata_o" : "dbus_rdata_o", ram_model[idx], rdata);
		end

		// unmapped access and an empty board offset
		bus_xfer(1'b1, 1'b0, UNMAPPED_ADDR, '1, '0, rdata, ack_d, err_d, t_d);
		compare_word("dbus_err_o", DATA_W'(1), DATA_W'(err_d));
		compare_word("dbus_ack_o", '0, DATA_W'(ack_d));
		bus_xfer(1'b0, 1'b1, UNMAPPED_ADDR, '1, 32'hDEAD_BEEF, rdata, ack_i, err_i, t_i);
		compare_word("ibus_err_o", DATA_W'(1), DATA_W'(err_i));
		compare_word("ibus_ack_o", '0, DATA_W'(ack_i));
		bus_read(1'b0, brd_word(6'd5), rdata);
		compare_word("ibus_rdata_o", '0, rdata);

		// LED register
		bus_write(1'b1, brd_word(BOARD_REG_LED), '1, 32'h0000_00A5);
		compare_word("led_o", 32'h0000_00A5, DATA_W'(led_o));
		bus_read(1'b0, brd_word(BOARD_REG_LED), rdata);
		compare_word("ibus_rdata_o", 32'h0000_00A5, rdata);
		bus_write(1'b1, brd_word(BOARD_REG_LED), 4'b1110, 32'h0000_003C);
		compare_word("led_o", 32'h0000_00A5, DATA_W'(led_o));

		// debounced switches and a short glitch
		switch_i = 8'h5A;
		wait_cycles(DEBOUNCE_MAX + 4);
		bus_read(1'b1, brd_word(BOARD_REG_SWITCH), rdata);
		compare_word("dbus_rdata_o", 32'h0000_005A, rdata);
		// a glitch that got through would set the sticky switch-change bit
		bus_write(1'b1, brd_word(BOARD_REG_IRQ), '1, 32'h0000_0003);
		switch_i = 8'h5B;
		wait_cycles(2);
		switch_i = 8'h5A;
		wait_cycles(DEBOUNCE_MAX + 4);
		bus_read(1'b1, brd_word(BOARD_REG_SWITCH), rdata);
		compare_word("dbus_rdata_o", 32'h0000_005A, rdata);
		bus_read(1'b1, brd_word(BOARD_REG_IRQ), rdata);
		compare_word("irq status bit 1", '0, DATA_W'(rdata[1]));

		// button interrupt, clear, and the stretched irq line
		bus_write(1'b1, brd_word(BOARD_REG_IRQ), '1, 32'h0000_0003);
		button_i = 4'b0001;
		wait_cycles(DEBOUNCE_MAX + 4);
		tries = 0;
		rdata = '0;
		while (!rdata[0] && tries < 10) begin
			bus_read(1'b0, brd_word(BOARD_REG_IRQ), rdata);
			tries++;
		end
		compare_word("irq status bit 0", DATA_W'(1), DATA_W'(rdata[0]));
		tries = 0;
		while (!irq_o[0] && tries < BUS_TIMEOUT) begin
			@(negedge clk_cpu);
			tries++;
		end
		expect_true(irq_o[0], "irq_o[0] did not rise after the button press");
		bus_write(1'b1, brd_word(BOARD_REG_IRQ), '1, 32'h0000_0001);
		tries = 0;
		while (irq_o[0] && tries < IR_HOLD + 3) begin
			@(negedge clk_cpu);
			tries++;
		end
		compare_word("irq_o[0]", '0, DATA_W'(irq_o[0]));
		bus_read(1'b0, brd_word(BOARD_REG_IRQ), rdata);
		compare_word("irq status bit 0", '0, DATA_W'(rdata[0]));

		// both masters in the same cycle with dbus taking priority
		idx = 8'h21;
		idx_b = 8'h84;
		wdata = $urandom;
		fork
			bus_xfer(1'b1, 1'b1, ram_word(idx), '1, wdata, rd_d, ack_d, err_d, t_d);
			bus_xfer(1'b0, 1'b1, ram_word(idx_b), '1, ~wdata, rd_i, ack_i, err_i, t_i);
		join
		expect_true(ack_d && ack_i, "simultaneous writes were not both acked");
		expect_true(t_d < t_i, "dbus write was not acked before ibus write");
		ram_model[idx] = wdata;
		ram_model[idx_b] = ~wdata;
		fork
			bus_xfer(1'b1, 1'b0, ram_word(idx), '1, '0, rd_d, ack_d, err_d, t_d);
			bus_xfer(1'b0, 1'b0, ram_word(idx_b), '1, '0, rd_i, ack_i, err_i, t_i);
		join
		expect_true(ack_d && ack_i, "simultaneous reads were not both acked");
		expect_true(t_d < t_i, "dbus read was not acked before ibus read");
		compare_word("dbus_rdata_o", ram_model[idx], rd_d);
		compare_word("ibus_rdata_o", ram_model[idx_b], rd_i);

		$display("errors: %0d", errors);
		if (errors == 0) begin
			$display("ALL TESTS PASSED");
		end else begin
			$display("SOME TESTS FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- vlog.f
soc_pkg.sv
reset_gen.sv
anti_jitter.sv
wb_arb.sv
wb_ram.sv
wb_board.sv
ir_conv.sv
soc_top.sv
soc_sva.sv
tb_soc.sv

//--- wb_arb.sv
`timescale 1ns/1ns
`default_nettype none

module wb_arb (
	input  logic                        clk_cpu,
	input  logic                        sys_rst_i,
	// instruction-side master
	input  logic                        ibus_cyc_i,
	input  logic                        ibus_stb_i,
	input  logic                        ibus_we_i,
	input  logic [soc_pkg::WADDR_W-1:0] ibus_addr_i,
	input  logic [soc_pkg::SEL_W-1:0]   ibus_sel_i,
	input  logic [soc_pkg::DATA_W-1:0]  ibus_wdata_i,
	output logic [soc_pkg::DATA_W-1:0]  ibus_rdata_o,
	output logic                        ibus_ack_o,
	output logic                        ibus_err_o,
	// data-side master
	input  logic                        dbus_cyc_i,
	input  logic                        dbus_stb_i,
	input  logic                        dbus_we_i,
	input  logic [soc_pkg::WADDR_W-1:0] dbus_addr_i,
	input  logic [soc_pkg::SEL_W-1:0]   dbus_sel_i,
	input  logic [soc_pkg::DATA_W-1:0]  dbus_wdata_i,
	output logic [soc_pkg::DATA_W-1:0]  dbus_rdata_o,
	output logic                        dbus_ack_o,
	output logic                        dbus_err_o,
	// shared slave request
	output logic                        s_we_o,
	output logic [soc_pkg::WADDR_W-1:0] s_addr_o,
	output logic [soc_pkg::SEL_W-1:0]   s_sel_o,
	output logic [soc_pkg::DATA_W-1:0]  s_wdata_o,
	output logic                        ram_stb_o,
	input  logic [soc_pkg::DATA_W-1:0]  ram_rdata_i,
	input  logic                        ram_ack_i,
	output logic                        brd_stb_o,
	input  logic [soc_pkg::DATA_W-1:0]  brd_rdata_i,
	input  logic                        brd_ack_i
);
	import soc_pkg::*;

	arb_state_e arb_state;
	arb_state_e arb_next;
	slave_e     slave_sel;

	logic               m_cyc;
	logic               m_stb;
	logic               m_we;
	logic [WADDR_W-1:0] m_addr;
	logic [SEL_W-1:0]   m_sel;
	logic [DATA_W-1:0]  m_wdata;
	logic               m_req;
	logic               s_ack;
	logic [DATA_W-1:0]  s_rdata;
	logic               err_q;
	logic               err_served;

	// fixed priority, dbus first; grant held until cyc drops
	always_comb begin
		arb_next = arb_state;
		case (arb_state)
			ARB_IDLE: begin
				if (dbus_cyc_i && dbus_stb_i) begin
					arb_next = ARB_DBUS;
				end else if (ibus_cyc_i && ibus_stb_i) begin
					arb_next = ARB_IBUS;
				end
			end
			ARB_IBUS: begin
				if (!ibus_cyc_i) begin
					arb_next = ARB_IDLE;
				end
			end
			ARB_DBUS: begin
				if (!dbus_cyc_i) begin
					arb_next = ARB_IDLE;
				end
			end
			default: arb_next = ARB_IDLE;
		endcase
	end

	// granted master onto the shared path
	always_comb begin
		if (arb_state == ARB_DBUS) begin
			m_cyc = dbus_cyc_i;
			m_stb = dbus_stb_i;
			m_we = dbus_we_i;
			m_addr = dbus_addr_i;
			m_sel = dbus_sel_i;
			m_wdata = dbus_wdata_i;
		end else begin
			m_cyc = ibus_cyc_i;
			m_stb = ibus_stb_i;
			m_we = ibus_we_i;
			m_addr = ibus_addr_i;
			m_sel = ibus_sel_i;
			m_wdata = ibus_wdata_i;
		end
	end

	assign m_req = (arb_state != ARB_IDLE) && m_cyc && m_stb;

	// word address, so byte bits 31:24 sit at the top 8 bits
	always_comb begin
		if (m_addr[WADDR_W-1 -: 8] == RAM_PAGE) begin
			slave_sel = SLV_RAM;
		end else if (m_addr[WADDR_W-1 -: 16] == DEV_PAGE) begin
			slave_sel = SLV_BOARD;
		end else begin
			slave_sel = SLV_NONE;
		end
	end

	assign ram_stb_o = m_req && (slave_sel == SLV_RAM);
	assign brd_stb_o = m_req && (slave_sel == SLV_BOARD);
	assign s_we_o = m_we;
	assign s_addr_o = m_addr;
	assign s_sel_o = m_sel;
	assign s_wdata_o = m_wdata;

	assign s_ack = ((slave_sel == SLV_RAM) && ram_ack_i) ||
		((slave_sel == SLV_BOARD) && brd_ack_i);
	assign s_rdata = (slave_sel == SLV_BOARD) ? brd_rdata_i : ram_rdata_i;

	assign ibus_ack_o = (arb_state == ARB_IBUS) && s_ack;
	assign ibus_err_o = (arb_state == ARB_IBUS) && err_q;
	assign ibus_rdata_o = s_rdata;
	assign dbus_ack_o = (arb_state == ARB_DBUS) && s_ack;
	assign dbus_err_o = (arb_state == ARB_DBUS) && err_q;
	assign dbus_rdata_o = s_rdata;

	always_ff @(posedge clk_cpu or posedge sys_rst_i) begin
		if (sys_rst_i) begin
			arb_state <= ARB_IDLE;
			err_q <= 1'b0;
			err_served <= 1'b0;
		end else begin
			arb_state <= arb_next;
			// one err per strobe, like a slave ack
			err_q <= m_req && (slave_sel == SLV_NONE) && !err_q && !err_served;
			err_served <= m_req && (err_served || err_q);
		end
	end

endmodule

`default_nettype wire

//--- wb_board.sv
`timescale 1ns/1ns
`default_nettype none

module wb_board (
	input  logic                         clk_cpu,
	input  logic                         sys_rst_i,
	input  logic                         stb_i,
	input  logic                         we_i,
	input  logic [5:0]                   addr_i,
	input  logic [soc_pkg::SEL_W-1:0]    sel_i,
	input  logic [soc_pkg::DATA_W-1:0]   wdata_i,
	output logic [soc_pkg::DATA_W-1:0]   rdata_o,
	output logic                         ack_o,
	input  logic [soc_pkg::SWITCH_W-1:0] switch_i,
	input  logic [soc_pkg::BUTTON_W-1:0] button_i,
	output logic [soc_pkg::SWITCH_W-1:0] led_o,
	output logic [soc_pkg::IRQ_W-1:0]    irq_o
);
	import soc_pkg::*;

	logic                served;
	logic                wr_en;
	logic [SWITCH_W-1:0] sw_q;
	logic [BUTTON_W-1:0] btn_q;
	logic [IRQ_W-1:0]    irq_status;
	logic [IRQ_W-1:0]    irq_set;
	logic [IRQ_W-1:0]    irq_clr;

	// write once, in the cycle the strobe is first seen
	assign wr_en = stb_i && we_i && !ack_o && !served;

	// bit 1 switch change, bit 0 button press
	assign irq_set = {|(switch_i ^ sw_q), |(button_i & ~btn_q)};
	assign irq_clr = (wr_en && addr_i == BOARD_REG_IRQ && sel_i[0]) ?
		wdata_i[IRQ_W-1:0] : '0;

	assign irq_o = irq_status;

	always_ff @(posedge clk_cpu or posedge sys_rst_i) begin
		if (sys_rst_i) begin
			ack_o <= 1'b0;
			served <= 1'b0;
			sw_q <= '0;
			btn_q <= '0;
			led_o <= '0;
			irq_status <= '0;
		end else begin
			ack_o <= stb_i && !ack_o && !served;
			served <= stb_i && (served || ack_o);
			sw_q <= switch_i;
			btn_q <= button_i;
			if (wr_en && addr_i == BOARD_REG_LED && sel_i[0]) begin
				led_o <= wdata_i[SWITCH_W-1:0];
			end
			// a new event wins over a clear in the same cycle
			irq_status <= (irq_status & ~irq_clr) | irq_set;
		end
	end

	always_ff @(posedge clk_cpu) begin
		if (stb_i) begin
			case (addr_i)
				BOARD_REG_SWITCH: rdata_o <= DATA_W'({button_i, switch_i});
				BOARD_REG_LED:    rdata_o <= DATA_W'(led_o);
				BOARD_REG_IRQ:    rdata_o <= DATA_W'(irq_status);
				default:          rdata_o <= '0;
			endcase
		end
	end

endmodule

`default_nettype wire

//--- wb_ram.sv
`timescale 1ns/1ns
`default_nettype none

module wb_ram #(
	parameter int RAM_ADDR_W = 8
) (
	input  logic                       clk_cpu,
	input  logic                       sys_rst_i,
	input  logic                       stb_i,
	input  logic                       we_i,
	input  logic [RAM_ADDR_W-1:0]      addr_i,
	input  logic [soc_pkg::SEL_W-1:0]  sel_i,
	input  logic [soc_pkg::DATA_W-1:0] wdata_i,
	output logic [soc_pkg::DATA_W-1:0] rdata_o,
	output logic                       ack_o
);
	import soc_pkg::*;

	logic [DATA_W-1:0] mem [2**RAM_ADDR_W];
	logic              served;

	always_ff @(posedge clk_cpu) begin
		if (stb_i && we_i) begin
			for (int b = 0; b < SEL_W; b++) begin
				if (sel_i[b]) begin
					mem[addr_i][8*b +: 8] <= wdata_i[8*b +: 8];
				end
			end
		end
		if (stb_i) begin
			rdata_o <= mem[addr_i];
		end
	end

	// single ack per strobe, re-armed once stb goes low
	always_ff @(posedge clk_cpu or posedge sys_rst_i) begin
		if (sys_rst_i) begin
			ack_o <= 1'b0;
			served <= 1'b0;
		end else begin
			ack_o <= stb_i && !ack_o && !served;
			served <= stb_i && (served || ack_o);
		end
	end

endmodule

`default_nettype wire
